// ==== src/task_unit_consts.svh ====
`ifndef TASK_UNIT_CONSTS_SVH
`define TASK_UNIT_CONSTS_SVH

// Queue holds 2**TQ_STAGES - 1 tasks
`define TQ_STAGES             4
`define TQ_DEPTH              ((1 << `TQ_STAGES) - 1)

`define TS_WIDTH              32
`define LOCALE_WIDTH          32
`define ARG_WIDTH             32
`define TTYPE_WIDTH           4
`define TTYPE_SPLITTER        4'hf

`define SPILL_FIFO_LOG_DEPTH  3
// One DEQ_MAX can be in flight at a time
`define SPILL_FIFO_HEADROOM   6

`define CFG_ADDR_WIDTH        4
`define CFG_DATA_WIDTH        32

`define ADDR_SPILL_THRESHOLD  4'h0
`define ADDR_SPILL_SIZE       4'h1
`define ADDR_START            4'h2
`define ADDR_THROTTLE_MARGIN  4'h3

`define RST_SPILL_THRESHOLD   4'd12
`define RST_SPILL_SIZE        4'd4
`define RST_THROTTLE_MARGIN   32'd0

`endif

// ==== src/task_types_pkg.sv ====
`include "task_unit_consts.svh"

package task_types_pkg;

   typedef logic [`TS_WIDTH-1:0]     ts_t;
   typedef logic [`TTYPE_WIDTH-1:0]  ttype_t;
   typedef logic [`LOCALE_WIDTH-1:0] locale_t;
   typedef logic [`ARG_WIDTH-1:0]    args_t;

   // Timestamp sits in the top bits
   typedef struct packed {
      ts_t     ts;
      ttype_t  ttype;
      locale_t locale;
      args_t   args;
   } task_t;

endpackage

// ==== src/unit_ctrl_pkg.sv ====
`include "task_unit_consts.svh"

package unit_ctrl_pkg;

   typedef enum logic [2:0] {
      NOP,
      ENQ,
      DEQ_MIN,
      REPLACE,
      DEQ_MAX
   } queue_op_t;

   typedef logic [`TQ_STAGES-1:0]      count_t;
   typedef logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_t;
   typedef logic [`CFG_DATA_WIDTH-1:0] cfg_data_t;

endpackage

// ==== src/enq_arbiter.sv ====
`timescale 1ns/1ps

module enq_arbiter
   import task_types_pkg::*;
(
   input  logic  clk,
   input  logic  rstn,
   input  logic  coal_child_valid,
   input  task_t coal_child_data,
   input  logic  task_enq_valid,
   input  task_t task_enq_data,
   input  logic  insert_take,
   input  logic  spilling,
   output logic  coal_child_ready,
   output logic  task_enq_ready,
   output logic  insert_valid,
   output task_t insert_task
);

   logic can_accept;

   assign can_accept       = !insert_valid && !spilling;
   // Coalescer children win over new tasks
   assign coal_child_ready = can_accept && coal_child_valid;
   assign task_enq_ready   = can_accept && !coal_child_valid && task_enq_valid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         insert_valid <= 1'b0;
      end else if (coal_child_ready || task_enq_ready) begin
         insert_valid <= 1'b1;
      end else if (insert_take) begin
         insert_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (coal_child_ready) begin
         insert_task <= coal_child_data;
      end else if (task_enq_ready) begin
         insert_task <= task_enq_data;
      end
   end

   // Queue only takes a task that the register really holds
   a_take_held : assert property (@(posedge clk) disable iff (!rstn)
      insert_take |-> insert_valid);

endmodule

// ==== src/sorted_task_queue.sv ====
`timescale 1ns/1ps
`include "task_unit_consts.svh"

module sorted_task_queue
   import task_types_pkg::*, unit_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      rstn,
   input  queue_op_t op,
   input  task_t     in_task,
   output logic      queue_ready,
   output logic      head_valid,
   output task_t     head_task,
   output logic      max_valid,
   output task_t     max_task,
   output count_t    count
);

   // Entry 0 holds the lowest timestamp
   task_t  entries [`TQ_DEPTH];
   task_t  base    [`TQ_DEPTH];
   task_t  next_e  [`TQ_DEPTH];
   count_t base_cnt;
   count_t ins_pos;
   logic   shift;
   logic   do_ins;
   logic   busy;

   assign queue_ready = !busy;
   assign head_valid  = (count != '0);
   assign head_task   = entries[0];

   assign shift  = (op == DEQ_MIN) || (op == REPLACE);
   assign do_ins = (op == ENQ) || (op == REPLACE);

   always_comb begin
      for (int i = 0; i < `TQ_DEPTH - 1; i++) begin
         base[i] = shift ? entries[i+1] : entries[i];
      end
      base[`TQ_DEPTH-1] = entries[`TQ_DEPTH-1];
      base_cnt = shift ? count - 1'b1 : count;

      // Equal timestamps go behind the ones already queued
      ins_pos = '0;
      for (int i = 0; i < `TQ_DEPTH; i++) begin
         if ((i < base_cnt) && (base[i].ts <= in_task.ts)) begin
            ins_pos = ins_pos + 1'b1;
         end
      end

      next_e[0] = (do_ins && (ins_pos == '0)) ? in_task : base[0];
      for (int i = 1; i < `TQ_DEPTH; i++) begin
         if (!do_ins || (i < ins_pos)) begin
            next_e[i] = base[i];
         end else if (i == ins_pos) begin
            next_e[i] = in_task;
         end else begin
            next_e[i] = base[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (op != NOP) begin
         entries <= next_e;
      end
      if (op == DEQ_MAX) begin
         max_task <= entries[count - 1'b1];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         count     <= '0;
         busy      <= 1'b0;
         max_valid <= 1'b0;
      end else begin
         // One idle cycle after every operation
         busy      <= (op != NOP);
         max_valid <= (op == DEQ_MAX);
         case (op)
            ENQ:              count <= count + 1'b1;
            DEQ_MIN, DEQ_MAX: count <= count - 1'b1;
            default:          count <= count;
         endcase
      end
   end

   a_no_enq_full : assert property (@(posedge clk) disable iff (!rstn)
      (op == ENQ) |-> (count != count_t'(`TQ_DEPTH)));
   a_no_deq_empty : assert property (@(posedge clk) disable iff (!rstn)
      (op inside {DEQ_MIN, REPLACE, DEQ_MAX}) |-> (count != '0));

endmodule

// ==== src/spill_controller.sv ====
`timescale 1ns/1ps
`include "task_unit_consts.svh"

module spill_controller
   import unit_ctrl_pkg::*;
(
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         almost_full,
   input  count_t                       spill_size,
   input  logic                         queue_ready,
   input  logic                         head_valid,
   input  logic                         insert_valid,
   input  logic                         head_taken,
   input  logic [`SPILL_FIFO_LOG_DEPTH:0] fifo_count,
   output queue_op_t                    op,
   output logic                         insert_take,
   output logic                         spilling
);

   count_t spill_cnt;

   assign spilling = (spill_cnt != '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         spill_cnt <= '0;
      end else if (!spilling && almost_full) begin
         spill_cnt <= spill_size;
      end else if (op == DEQ_MAX) begin
         spill_cnt <= spill_cnt - 1'b1;
      end else if (spilling && !head_valid) begin
         // Queue ran dry before the spill finished
         spill_cnt <= '0;
      end
   end

   always_comb begin
      op          = NOP;
      insert_take = 1'b0;
      if (queue_ready) begin
         if (spilling) begin
            if ((fifo_count < `SPILL_FIFO_HEADROOM) && head_valid) begin
               op = DEQ_MAX;
            end
         end else if (insert_valid && head_taken) begin
            op          = REPLACE;
            insert_take = 1'b1;
         end else if (insert_valid) begin
            op          = ENQ;
            insert_take = 1'b1;
         end else if (head_taken) begin
            op = DEQ_MIN;
         end
      end
   end

endmodule

// ==== src/spill_fifo.sv ====
`timescale 1ns/1ps
`include "task_unit_consts.svh"

module spill_fifo
   import task_types_pkg::*;
(
   input  logic                           clk,
   input  logic                           rstn,
   input  logic                           wr_en,
   input  task_t                          wr_task,
   input  logic                           overflow_ready,
   output logic                           overflow_valid,
   output task_t                          overflow_data,
   output logic [`SPILL_FIFO_LOG_DEPTH:0] fifo_count
);

   localparam int DEPTH = 1 << `SPILL_FIFO_LOG_DEPTH;

   task_t                           mem [DEPTH];
   logic [`SPILL_FIFO_LOG_DEPTH-1:0] wr_ptr;
   logic [`SPILL_FIFO_LOG_DEPTH-1:0] rd_ptr;
   logic                            rd_en;

   assign overflow_valid = (fifo_count != '0);
   assign overflow_data  = mem[rd_ptr];
   assign rd_en          = overflow_valid && overflow_ready;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_task;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_count <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         fifo_count <= fifo_count + wr_en - rd_en;
      end
   end

   // Headroom in the spill controller must keep this from happening
   a_no_overrun : assert property (@(posedge clk) disable iff (!rstn)
      wr_en |-> (fifo_count < DEPTH));

endmodule

// ==== src/deq_steer.sv ====
`timescale 1ns/1ps
`include "task_unit_consts.svh"

module deq_steer
   import task_types_pkg::*;
(
   input  logic  clk,
   input  logic  rstn,
   input  logic  queue_ready,
   input  logic  head_valid,
   input  task_t head_task,
   input  logic  started,
   input  ts_t   throttle_ts,
   input  logic  task_deq_ready,
   input  logic  splitter_deq_ready,
   input  logic  spilling,
   input  logic  empty,
   output logic  task_deq_valid,
   output task_t task_deq_data,
   output logic  splitter_deq_valid,
   output task_t splitter_deq_task,
   output logic  head_taken,
   output ts_t   lvt
);

   logic offer;
   logic is_splitter;

   assign offer       = queue_ready && head_valid && !spilling;
   assign is_splitter = (head_task.ttype == `TTYPE_SPLITTER);

   assign splitter_deq_valid = offer && is_splitter;
   assign splitter_deq_task  = head_task;
   // Commit port waits for start and the throttle bound
   assign task_deq_valid = offer && !is_splitter && started && (head_task.ts < throttle_ts);
   assign task_deq_data  = head_task;

   assign head_taken = (task_deq_valid && task_deq_ready) ||
                       (splitter_deq_valid && splitter_deq_ready);

   // Head entry is current whenever the queue holds a task
   assign lvt = empty ? '1 : head_task.ts;

   // A taken head must start a dequeue, so the queue rests next cycle
   a_rest_after_take : assert property (@(posedge clk) disable iff (!rstn)
      head_taken |=> !(task_deq_valid || splitter_deq_valid));

endmodule

// ==== src/task_unit_config.sv ====
`timescale 1ns/1ps
`include "task_unit_consts.svh"

module task_unit_config
   import task_types_pkg::*, unit_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      rstn,
   input  logic      cfg_wvalid,
   input  cfg_addr_t cfg_waddr,
   input  cfg_data_t cfg_wdata,
   input  ts_t       gvt,
   output count_t    spill_threshold,
   output count_t    spill_size,
   output logic      started,
   output ts_t       throttle_ts
);

   ts_t throttle_margin;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         spill_threshold <= `RST_SPILL_THRESHOLD;
         spill_size      <= `RST_SPILL_SIZE;
         started         <= 1'b0;
         throttle_margin <= `RST_THROTTLE_MARGIN;
      end else if (cfg_wvalid) begin
         case (cfg_waddr)
            `ADDR_SPILL_THRESHOLD: spill_threshold <= cfg_wdata[`TQ_STAGES-1:0];
            `ADDR_SPILL_SIZE:      spill_size      <= cfg_wdata[`TQ_STAGES-1:0];
            `ADDR_START:           started         <= cfg_wdata[0];
            `ADDR_THROTTLE_MARGIN: throttle_margin <= cfg_wdata[`TS_WIDTH-1:0];
            default: ;
         endcase
      end
   end

   // Zero margin turns throttling off
   always_ff @(posedge clk) begin
      throttle_ts <= (throttle_margin == '0) ? '1 : gvt + throttle_margin;
   end

endmodule

// ==== src/task_unit_top.sv ====
`timescale 1ns/1ps
`include "task_unit_consts.svh"

module task_unit_top
   import task_types_pkg::*, unit_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      rstn,
   input  logic      task_enq_valid,
   output logic      task_enq_ready,
   input  task_t     task_enq_data,
   input  logic      coal_child_valid,
   output logic      coal_child_ready,
   input  task_t     coal_child_data,
   output logic      task_deq_valid,
   input  logic      task_deq_ready,
   output task_t     task_deq_data,
   output logic      splitter_deq_valid,
   input  logic      splitter_deq_ready,
   output task_t     splitter_deq_task,
   output logic      overflow_valid,
   input  logic      overflow_ready,
   output task_t     overflow_data,
   input  logic      cfg_wvalid,
   input  cfg_addr_t cfg_waddr,
   input  cfg_data_t cfg_wdata,
   input  ts_t       gvt,
   output logic      full,
   output logic      almost_full,
   output logic      empty,
   output ts_t       lvt
);

   logic                           insert_valid;
   task_t                          insert_task;
   logic                           insert_take;
   logic                           spilling;
   queue_op_t                      op;
   logic                           queue_ready;
   logic                           head_valid;
   task_t                          head_task;
   logic                           max_valid;
   task_t                          max_task;
   count_t                         count;
   logic                           head_taken;
   logic                           started;
   ts_t                            throttle_ts;
   count_t                         spill_threshold;
   count_t                         spill_size;
   logic [`SPILL_FIFO_LOG_DEPTH:0] fifo_count;

   assign empty       = (count == '0);
   assign almost_full = (count > spill_threshold);
   assign full        = (count == count_t'(`TQ_DEPTH));

   enq_arbiter u_enq_arbiter (
      .clk              (clk),
      .rstn             (rstn),
      .coal_child_valid (coal_child_valid),
      .coal_child_data  (coal_child_data),
      .task_enq_valid   (task_enq_valid),
      .task_enq_data    (task_enq_data),
      .insert_take      (insert_take),
      .spilling         (spilling),
      .coal_child_ready (coal_child_ready),
      .task_enq_ready   (task_enq_ready),
      .insert_valid     (insert_valid),
      .insert_task      (insert_task)
   );

   spill_controller u_spill_controller (
      .clk          (clk),
      .rstn         (rstn),
      .almost_full  (almost_full),
      .spill_size   (spill_size),
      .queue_ready  (queue_ready),
      .head_valid   (head_valid),
      .insert_valid (insert_valid),
      .head_taken   (head_taken),
      .fifo_count   (fifo_count),
      .op           (op),
      .insert_take  (insert_take),
      .spilling     (spilling)
   );

   sorted_task_queue u_queue (
      .clk         (clk),
      .rstn        (rstn),
      .op          (op),
      .in_task     (insert_task),
      .queue_ready (queue_ready),
      .head_valid  (head_valid),
      .head_task   (head_task),
      .max_valid   (max_valid),
      .max_task    (max_task),
      .count       (count)
   );

   spill_fifo u_spill_fifo (
      .clk            (clk),
      .rstn           (rstn),
      .wr_en          (max_valid),
      .wr_task        (max_task),
      .overflow_ready (overflow_ready),
      .overflow_valid (overflow_valid),
      .overflow_data  (overflow_data),
      .fifo_count     (fifo_count)
   );

   deq_steer u_deq_steer (
      .clk                (clk),
      .rstn               (rstn),
      .queue_ready        (queue_ready),
      .head_valid         (head_valid),
      .head_task          (head_task),
      .started            (started),
      .throttle_ts        (throttle_ts),
      .task_deq_ready     (task_deq_ready),
      .splitter_deq_ready (splitter_deq_ready),
      .spilling           (spilling),
      .empty              (empty),
      .task_deq_valid     (task_deq_valid),
      .task_deq_data      (task_deq_data),
      .splitter_deq_valid (splitter_deq_valid),
      .splitter_deq_task  (splitter_deq_task),
      .head_taken         (head_taken),
      .lvt                (lvt)
   );

   task_unit_config u_config (
      .clk             (clk),
      .rstn            (rstn),
      .cfg_wvalid      (cfg_wvalid),
      .cfg_waddr       (cfg_waddr),
      .cfg_wdata       (cfg_wdata),
      .gvt             (gvt),
      .spill_threshold (spill_threshold),
      .spill_size      (spill_size),
      .started         (started),
      .throttle_ts     (throttle_ts)
   );

endmodule

// ==== test/tb_task_unit.sv ====
`timescale 1ns/1ps
`include "task_unit_consts.svh"

module tb_task_unit
   import task_types_pkg::*, unit_ctrl_pkg::*;
();

   logic      clk;
   logic      rstn;
   logic      task_enq_valid;
   logic      task_enq_ready;
   task_t     task_enq_data;
   logic      coal_child_valid;
   logic      coal_child_ready;
   task_t     coal_child_data;
   logic      task_deq_valid;
   logic      task_deq_ready;
   task_t     task_deq_data;
   logic      splitter_deq_valid;
   logic      splitter_deq_ready;
   task_t     splitter_deq_task;
   logic      overflow_valid;
   logic      overflow_ready;
   task_t     overflow_data;
   logic      cfg_wvalid;
   cfg_addr_t cfg_waddr;
   cfg_data_t cfg_wdata;
   ts_t       gvt;
   logic      full;
   logic      almost_full;
   logic      empty;
   ts_t       lvt;

   // Reference model: every task accepted and not yet seen leaving
   task_t model [$];
   bit    check_order;
   ts_t   throttle_bound;
   int    errors;
   int    tests_run;
   int    tests_failed;
   int    err_at_start;
   int    n_acc;
   int    n_deq;
   int    n_ovf;
   ts_t   max_deq_ts;
   ts_t   min_ovf_ts;

   task_unit_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (200000) @(posedge clk);
      $display("Simulation ran too long without finishing the test sequence");
      $display("*** TEST FAILED ***");
      $finish;
   end

   task automatic check_task(input task_t exp, input task_t got, input string what);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
      end
   endtask

   task automatic check_ts(input ts_t exp, input ts_t got, input string what);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
      end
   endtask

   task automatic check_flag(input logic exp, input logic got, input string what);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
      end
   endtask

   function automatic int find_match(input task_t t);
      for (int i = 0; i < model.size(); i++) begin
         if (model[i] === t) return i;
      end
      return -1;
   endfunction

   function automatic int min_index();
      int mi;
      mi = 0;
      for (int i = 1; i < model.size(); i++) begin
         if (model[i].ts < model[mi].ts) mi = i;
      end
      return mi;
   endfunction

   function automatic int count_below(input ts_t bound);
      int n;
      n = 0;
      foreach (model[i]) begin
         if (model[i].ts < bound) n++;
      end
      return n;
   endfunction

   // Removes a departing task from the model, head order checked when asked
   task automatic take_from_model(input task_t got, input string port, input bit ordered);
      int idx;
      int mi;
      idx = find_match(got);
      if (model.size() == 0) begin
         errors++;
         $display("At %0t the %s released a task while none was held", $time, port);
      end else begin
         mi = min_index();
         if (ordered && (idx < 0 || model[idx].ts != model[mi].ts)) idx = mi;
         if (idx < 0) begin
            errors++;
            $display("At %0t the %s released a task that was never enqueued", $time, port);
         end else begin
            check_task(model[idx], got, port);
            model.delete(idx);
         end
      end
   endtask

   always @(negedge clk) begin
      if (rstn) begin
         if (task_deq_valid && task_deq_ready) begin
            if (task_deq_data.ttype == `TTYPE_SPLITTER) begin
               errors++;
               $display("At %0t a splitter task left on the commit port", $time);
            end
            if (task_deq_data.ts >= throttle_bound) begin
               errors++;
               $display("At %0t the commit port released ts %0d above the throttle bound",
                        $time, task_deq_data.ts);
            end
            n_deq++;
            if (task_deq_data.ts > max_deq_ts) max_deq_ts = task_deq_data.ts;
            take_from_model(task_deq_data, "commit port", check_order);
         end
         if (splitter_deq_valid && splitter_deq_ready) begin
            if (splitter_deq_task.ttype != `TTYPE_SPLITTER) begin
               errors++;
               $display("At %0t a non-splitter task left on the splitter port", $time);
            end
            n_deq++;
            if (splitter_deq_task.ts > max_deq_ts) max_deq_ts = splitter_deq_task.ts;
            take_from_model(splitter_deq_task, "splitter port", check_order);
         end
         if (overflow_valid && overflow_ready) begin
            n_ovf++;
            if (overflow_data.ts < min_ovf_ts) min_ovf_ts = overflow_data.ts;
            take_from_model(overflow_data, "overflow port", 1'b0);
         end
         // Accepted tasks enter after departures of the same cycle
         if (coal_child_valid && coal_child_ready) begin
            model.push_back(coal_child_data);
            n_acc++;
         end else if (task_enq_valid && task_enq_ready) begin
            model.push_back(task_enq_data);
            n_acc++;
         end
      end
   end

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic idle(input int n);
      repeat (n) tick();
   endtask

   task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
      cfg_wvalid = 1'b1;
      cfg_waddr  = addr;
      cfg_wdata  = data;
      tick();
      cfg_wvalid = 1'b0;
   endtask

   function automatic task_t rand_task(input ts_t lo, input ts_t span, input bit splitter);
      task_t t;
      t.ts     = lo + ($urandom % span);
      t.ttype  = splitter ? `TTYPE_SPLITTER : ttype_t'($urandom % `TTYPE_SPLITTER);
      t.locale = $urandom;
      t.args   = $urandom;
      return t;
   endfunction

   task automatic enqueue(input task_t t, input bit coal, input int limit, input bit must,
                          output bit ok);
      int n;
      bit rdy;
      if (coal) begin
         coal_child_valid = 1'b1;
         coal_child_data  = t;
      end else begin
         task_enq_valid = 1'b1;
         task_enq_data  = t;
      end
      n = 0;
      @(negedge clk);
      rdy = coal ? coal_child_ready : task_enq_ready;
      while (!rdy && n < limit) begin
         @(negedge clk);
         rdy = coal ? coal_child_ready : task_enq_ready;
         n++;
      end
      ok = rdy;
      tick();
      coal_child_valid = 1'b0;
      task_enq_valid   = 1'b0;
      if (!ok && must) begin
         errors++;
         $display("Enqueue port was not ready within %0d cycles", limit);
      end
   endtask

   // Random tasks on random ports, a third of them splitters when mixed
   task automatic fill(input int n, input ts_t lo, input ts_t span, input bit mix);
      bit ok;
      for (int i = 0; i < n; i++) begin
         enqueue(rand_task(lo, span, mix && ($urandom % 3 == 0)), $urandom % 2, 50, 1'b1, ok);
      end
   endtask

   task automatic wait_drained(input int limit);
      int n;
      n = 0;
      while (model.size() != 0 && n < limit) begin
         tick();
         n++;
      end
      if (model.size() != 0) begin
         errors++;
         $display("Timeout: %0d tasks still held after %0d cycles", model.size(), limit);
      end
   endtask

   task automatic wait_below(input ts_t bound, input int limit);
      int n;
      n = 0;
      while (count_below(bound) != 0 && n < limit) begin
         tick();
         n++;
      end
      if (count_below(bound) != 0) begin
         errors++;
         $display("Timeout: tasks below the throttle bound never left the unit");
      end
   endtask

   task automatic wait_empty(input int limit);
      int n;
      n = 0;
      while (!empty && n < limit) begin
         tick();
         n++;
      end
      if (!empty) begin
         errors++;
         $display("Timeout: empty flag stayed low for %0d cycles", limit);
      end
   endtask

   task automatic begin_test();
      err_at_start = errors;
      tests_run++;
   endtask

   task automatic end_test(input string name);
      if (errors != err_at_start) begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_at_start);
      end else begin
         $display("test %0d %s: passed", tests_run, name);
      end
   endtask

   initial begin
      bit  ok;
      int  acc0;
      int  tries;
      ts_t ts_next;
      task_t t;

      void'($urandom(32'h2ab7a2a4));
      errors             = 0;
      tests_run          = 0;
      tests_failed       = 0;
      n_acc              = 0;
      n_deq              = 0;
      n_ovf              = 0;
      check_order        = 1'b1;
      throttle_bound     = '1;
      max_deq_ts         = '0;
      min_ovf_ts         = '1;
      rstn               = 1'b0;
      task_enq_valid     = 1'b0;
      task_enq_data      = '0;
      coal_child_valid   = 1'b0;
      coal_child_data    = '0;
      task_deq_ready     = 1'b0;
      splitter_deq_ready = 1'b0;
      overflow_ready     = 1'b0;
      cfg_wvalid         = 1'b0;
      cfg_waddr          = '0;
      cfg_wdata          = '0;
      gvt                = '0;
      repeat (2) @(posedge clk);
      #1;
      rstn = 1'b1;
      tick();

      // Nothing may reach the commit port before start
      begin_test();
      task_deq_ready = 1'b1;
      fill(4, 0, 32'h1000_0000, 1'b0);
      for (int i = 0; i < 50; i++) begin
         @(negedge clk);
         if (task_deq_valid) begin
            errors++;
            $display("At %0t the commit port offered a task before start", $time);
         end
      end
      tick();
      task_deq_ready = 1'b0;
      end_test("start gate");

      begin_test();
      cfg_write(`ADDR_SPILL_THRESHOLD, 15);
      cfg_write(`ADDR_THROTTLE_MARGIN, 0);
      cfg_write(`ADDR_START, 1);
      fill(10, 0, 32'h1000_0000, 1'b0);
      idle(4);
      task_deq_ready = 1'b1;
      wait_drained(300);
      task_deq_ready = 1'b0;
      end_test("ordered drain");

      begin_test();
      fill(12, 0, 32'h0001_0000, 1'b1);
      idle(4);
      task_deq_ready     = 1'b1;
      splitter_deq_ready = 1'b1;
      wait_drained(300);
      task_deq_ready     = 1'b0;
      splitter_deq_ready = 1'b0;
      end_test("splitter routing");

      // Bound of gvt plus margin is 6000
      begin_test();
      gvt            = 5000;
      throttle_bound = 6000;
      cfg_write(`ADDR_THROTTLE_MARGIN, 1000);
      fill(10, 4000, 4000, 1'b0);
      idle(4);
      task_deq_ready = 1'b1;
      wait_below(6000, 300);
      idle(20);
      gvt            = 10000;
      throttle_bound = 11000;
      wait_drained(300);
      task_deq_ready = 1'b0;
      cfg_write(`ADDR_THROTTLE_MARGIN, 0);
      throttle_bound = '1;
      gvt            = '0;
      end_test("throttle");

      // Falling timestamps keep every spilled task above the ones that stay
      begin_test();
      check_order = 1'b0;
      cfg_write(`ADDR_SPILL_THRESHOLD, 8);
      cfg_write(`ADDR_SPILL_SIZE, 3);
      acc0       = n_acc;
      n_deq      = 0;
      n_ovf      = 0;
      max_deq_ts = '0;
      min_ovf_ts = '1;
      ts_next    = 32'h0010_0000;
      ok         = 1'b1;
      tries      = 0;
      while (ok && tries < 40) begin
         t    = rand_task(0, 1, 1'b0);
         t.ts = ts_next;
         enqueue(t, $urandom % 2, 40, 1'b0, ok);
         ts_next = ts_next - 1 - ($urandom % 256);
         tries++;
      end
      if (ok) begin
         errors++;
         $display("Enqueue ready never dropped while the overflow port was held off");
      end
      overflow_ready     = 1'b1;
      task_deq_ready     = 1'b1;
      splitter_deq_ready = 1'b1;
      wait_drained(600);
      if (n_ovf == 0) begin
         errors++;
         $display("No task was spilled to the overflow port");
      end
      if (n_ovf % 3 != 0) begin
         errors++;
         $display("Overflow count %0d is not a multiple of the spill size", n_ovf);
      end
      if (n_ovf + n_deq != n_acc - acc0) begin
         errors++;
         $display("Overflowed %0d plus dequeued %0d differs from %0d enqueued",
                  n_ovf, n_deq, n_acc - acc0);
      end
      if (n_deq != 0 && min_ovf_ts < max_deq_ts) begin
         errors++;
         $display("Spilled timestamp %0d is below dequeued timestamp %0d",
                  min_ovf_ts, max_deq_ts);
      end
      task_deq_ready     = 1'b0;
      splitter_deq_ready = 1'b0;
      check_order        = 1'b1;
      end_test("spill");

      begin_test();
      wait_empty(50);
      check_ts('1, lvt, "lvt when empty");
      fill(5, 100, 1000, 1'b0);
      idle(4);
      check_ts(model[min_index()].ts, lvt, "lvt while tasks held");
      check_flag(model.size() == 0, empty, "empty while tasks held");
      check_flag(model.size() == `TQ_DEPTH, full, "full below capacity");
      check_flag(model.size() > 8, almost_full, "almost_full below threshold");
      // Threshold 15 lets the queue reach capacity without a spill
      cfg_write(`ADDR_SPILL_THRESHOLD, 15);
      fill(`TQ_DEPTH - 5, 100, 1000, 1'b0);
      idle(4);
      check_flag(model.size() == `TQ_DEPTH, full, "full at capacity");
      check_flag(model.size() > 15, almost_full, "almost_full at threshold 15");
      cfg_write(`ADDR_SPILL_THRESHOLD, 14);
      check_flag(model.size() > 14, almost_full, "almost_full above threshold");
      task_deq_ready = 1'b1;
      wait_drained(300);
      task_deq_ready = 1'b0;
      wait_empty(50);
      check_flag(1'b0, full, "full after drain");
      check_flag(1'b0, almost_full, "almost_full after drain");
      check_ts('1, lvt, "lvt after drain");
      end_test("status");

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+src
src/task_types_pkg.sv
src/unit_ctrl_pkg.sv
src/enq_arbiter.sv
src/sorted_task_queue.sv
src/spill_controller.sv
src/spill_fifo.sv
src/deq_steer.sv
src/task_unit_config.sv
src/task_unit_top.sv
test/tb_task_unit.sv

// ==== Bender.yml ====
package:
  name: task_unit

export_include_dirs:
  - src

sources:
  - files:
      - src/task_types_pkg.sv
      - src/unit_ctrl_pkg.sv
      - src/enq_arbiter.sv
      - src/sorted_task_queue.sv
      - src/spill_controller.sv
      - src/spill_fifo.sv
      - src/deq_steer.sv
      - src/task_unit_config.sv
      - src/task_unit_top.sv
  - target: test
    files:
      - test/tb_task_unit.sv
